//--- hw/extractor_defs.svh
// Build constants for the packet extractor.
// Buffer geometry is fixed at four buffers of 256 words; packets must be
// 2 to 256 words long. API offsets are sized to the API address width.
`ifndef EXTRACTOR_DEFS_SVH
`define EXTRACTOR_DEFS_SVH

// Engine side
`define EXT_ENGINES       4
`define EXT_WORD_W        64
`define EXT_LWDV_W        4

// Buffer RAM geometry
`define EXT_BUF_SEL_W     2
`define EXT_BUF_ADDR_W    8

// API window
`define EXT_API_ADDR_W    12
`define EXT_API_BASE      12'h400
`define EXT_OFS_NAME0     12'h000
`define EXT_OFS_NAME1     12'h001
`define EXT_OFS_VERSION   12'h002
`define EXT_OFS_SCRATCH   12'h003
// Counters occupy offset and offset + 1 (high word first)
`define EXT_OFS_BYTES     12'h00a
`define EXT_OFS_PACKETS   12'h00c

// Identity, "NTS-EXTR" and "0.02"
`define EXT_CORE_NAME     64'h4e54_532d_4558_5452
`define EXT_CORE_VERSION  32'h302e_3032

`endif

//--- hw/extractor_engine_pkg.sv
// Types seen on the engine side of the extractor and in the buffer table.
// The word count of a full 256-word buffer wraps to zero.
`default_nettype none
`include "extractor_defs.svh"

package extractor_engine_pkg;

  // Inputs from one engine
  typedef struct packed {
    logic                    packet_available;
    logic                    fifo_empty;
    logic                    fifo_rd_valid;
    logic [`EXT_WORD_W-1:0]  fifo_rd_data;
    logic [`EXT_LWDV_W-1:0]  bytes_last_word;
  } engine_req_t;

  // Outputs to one engine, both single-cycle pulses
  typedef struct packed {
    logic packet_read;
    logic fifo_rd_start;
  } engine_rsp_t;

  typedef enum logic [1:0] {UNUSED, WRITING, LOADED, READING} buf_state_e;

  typedef struct packed {
    buf_state_e                 state;
    logic [`EXT_BUF_ADDR_W-1:0] words;
    logic [`EXT_LWDV_W-1:0]     last_bytes;
  } buf_entry_t;

endpackage

`default_nettype wire

//--- hw/extractor_host_pkg.sv
// Types seen on the host side of the extractor: Wishbone and MAC transmit.
// Byte 0 of a MAC word is its least significant byte.
`default_nettype none
`include "extractor_defs.svh"

package extractor_host_pkg;

  // Wishbone classic master outputs
  typedef struct packed {
    logic                       cyc;
    logic                       stb;
    logic                       we;
    logic [`EXT_API_ADDR_W-1:0] adr;
    logic [31:0]                dat;
  } wb_req_t;

  // One data word, read whole or byte by byte
  typedef union packed {
    logic [`EXT_WORD_W-1:0]            raw;
    logic [`EXT_WORD_W/8-1:0][7:0]     bytes;
  } mac_word_u;

  typedef struct packed {
    logic                     start;
    logic [`EXT_WORD_W/8-1:0] data_valid;
    mac_word_u                data;
  } mac_beat_t;

endpackage

`default_nettype wire

//--- hw/engine_mux.sv
// Round-robin engine multiplexer.
// Searches downward for an engine with a packet and stays on it until the
// packet has been read. Requests of the other engines read as zero.
`timescale 1ns/10ps
`default_nettype none
`include "extractor_defs.svh"

module engine_mux (
  input  wire logic                                              i_clk,
  input  wire logic                                              i_areset,
  input  wire extractor_engine_pkg::engine_req_t [`EXT_ENGINES-1:0] i_engines,
  output extractor_engine_pkg::engine_rsp_t      [`EXT_ENGINES-1:0] o_engines,
  output extractor_engine_pkg::engine_req_t                      o_sel_req,
  input  wire extractor_engine_pkg::engine_rsp_t                 i_sel_rsp
);

  localparam int IDX_W = (`EXT_ENGINES > 1) ? $clog2(`EXT_ENGINES) : 1;
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`EXT_ENGINES - 1);

  typedef enum logic {SEARCH, REMAIN} mux_state_e;

  mux_state_e       state_q;
  logic [IDX_W-1:0] idx_q;
  logic [IDX_W-1:0] idx_next;

  // Step downward with wraparound
  assign idx_next = (idx_q == '0) ? IDX_LAST : idx_q - 1'b1;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= SEARCH;
      idx_q   <= '0;
    end else begin
      case (state_q)
        SEARCH: begin
          if (i_engines[idx_q].packet_available) begin
            state_q <= REMAIN;
          end else begin
            idx_q <= idx_next;
          end
        end
        REMAIN: begin
          if (i_sel_rsp.packet_read) begin
            state_q <= SEARCH;
            idx_q   <= idx_next;
          end
        end
        default: state_q <= SEARCH;
      endcase
    end
  end

  always_comb begin
    o_sel_req        = '0;
    o_engines        = '0;
    o_engines[idx_q] = i_sel_rsp;
    if (state_q == REMAIN) begin
      o_sel_req = i_engines[idx_q];
    end
  end

  // The buffer side only talks to an engine the mux has locked on to
  a_rsp_in_remain: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_sel_rsp.packet_read || i_sel_rsp.fifo_rd_start) |-> state_q == REMAIN);

endmodule

`default_nettype wire

//--- hw/packet_buffers.sv
// Engine reader, buffer table and shared buffer RAM.
// Four buffers are filled in order and handed to the transmitter in the
// same order. Read data comes one cycle after the read address.
// When every buffer is busy no new packet is started.
`timescale 1ns/10ps
`default_nettype none
`include "extractor_defs.svh"

module packet_buffers (
  input  wire logic                               i_clk,
  input  wire logic                               i_areset,
  input  wire extractor_engine_pkg::engine_req_t  i_req,
  output extractor_engine_pkg::engine_rsp_t       o_rsp,
  input  wire logic [`EXT_BUF_ADDR_W-1:0]         i_rd_addr,
  output logic      [`EXT_WORD_W-1:0]             o_rd_data,
  output extractor_engine_pkg::buf_entry_t        o_head,
  input  wire logic                               i_head_done
);

  localparam int SEL_W   = `EXT_BUF_SEL_W;
  localparam int RAM_AW  = `EXT_BUF_SEL_W + `EXT_BUF_ADDR_W;
  localparam int BUFFERS = 1 << `EXT_BUF_SEL_W;

  extractor_engine_pkg::buf_entry_t buf_tab_q [BUFFERS];
  extractor_engine_pkg::buf_entry_t wr_entry;
  extractor_engine_pkg::buf_entry_t head_entry;

  logic [SEL_W-1:0] wr_sel_q;
  logic [SEL_W-1:0] head_sel_q;
  logic             rd_start_q;
  logic             pkt_read_q;

  // Registered write stage in front of the RAM
  logic                   wr_en_q;
  logic [RAM_AW-1:0]      wr_addr_q;
  logic [`EXT_WORD_W-1:0] wr_data_q;

  logic [`EXT_WORD_W-1:0] ram [2**RAM_AW];

  assign wr_entry          = buf_tab_q[wr_sel_q];
  assign head_entry        = buf_tab_q[head_sel_q];
  assign o_head            = head_entry;
  assign o_rsp.packet_read   = pkt_read_q;
  assign o_rsp.fifo_rd_start = rd_start_q;

  // --------------------------------------------------------------------------
  // Engine reader and head handover
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int i = 0; i < BUFFERS; i++) begin
        buf_tab_q[i] <= '0;
      end
      wr_sel_q   <= '0;
      head_sel_q <= '0;
      rd_start_q <= 1'b0;
      pkt_read_q <= 1'b0;
      wr_en_q    <= 1'b0;
    end else begin
      rd_start_q <= 1'b0;
      pkt_read_q <= 1'b0;
      wr_en_q    <= 1'b0;

      case (wr_entry.state)
        extractor_engine_pkg::UNUSED: begin
          if (i_req.packet_available && !i_req.fifo_empty) begin
            rd_start_q                      <= 1'b1;
            buf_tab_q[wr_sel_q].state       <= extractor_engine_pkg::WRITING;
            buf_tab_q[wr_sel_q].words       <= '0;
            buf_tab_q[wr_sel_q].last_bytes  <= i_req.bytes_last_word;
          end
        end
        extractor_engine_pkg::WRITING: begin
          if (i_req.fifo_rd_valid) begin
            wr_en_q                   <= 1'b1;
            buf_tab_q[wr_sel_q].words <= wr_entry.words + 1'b1;
          end else if (i_req.fifo_empty) begin
            pkt_read_q                <= 1'b1;
            buf_tab_q[wr_sel_q].state <= extractor_engine_pkg::LOADED;
            wr_sel_q                  <= wr_sel_q + 1'b1;
          end
        end
        default: ;
      endcase

      // The head is given to the transmitter as soon as it is loaded.
      // Reader and head never touch an entry in the same state.
      case (head_entry.state)
        extractor_engine_pkg::LOADED: begin
          buf_tab_q[head_sel_q].state <= extractor_engine_pkg::READING;
        end
        extractor_engine_pkg::READING: begin
          if (i_head_done) begin
            buf_tab_q[head_sel_q].state <= extractor_engine_pkg::UNUSED;
            head_sel_q                  <= head_sel_q + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    wr_addr_q <= {wr_sel_q, wr_entry.words};
    wr_data_q <= i_req.fifo_rd_data;
  end

  // --------------------------------------------------------------------------
  // Buffer RAM, write port from the engine, read port on the head buffer
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (wr_en_q) begin
      ram[wr_addr_q] <= wr_data_q;
    end
    o_rd_data <= ram[{head_sel_q, i_rd_addr}];
  end

  // The delayed write must still land in a buffer being filled
  a_write_in_writing: assert property (@(posedge i_clk) disable iff (i_areset)
    wr_en_q |-> buf_tab_q[wr_addr_q[RAM_AW-1 -: SEL_W]].state ==
                extractor_engine_pkg::WRITING);

endmodule

`default_nettype wire

//--- hw/mac_transmitter.sv
// MAC transmitter for the head buffer.
// The first word is held until ack, the rest follow without gaps. Bytes are
// reversed and invalid bytes of the last word are zeroed.
`timescale 1ns/10ps
`default_nettype none
`include "extractor_defs.svh"

module mac_transmitter (
  input  wire logic                              i_clk,
  input  wire logic                              i_areset,
  input  wire extractor_engine_pkg::buf_entry_t  i_head,
  output logic [`EXT_BUF_ADDR_W-1:0]             o_rd_addr,
  input  wire logic [`EXT_WORD_W-1:0]            i_rd_data,
  output logic                                   o_head_done,
  input  wire logic                              i_mac_tx_ack,
  output extractor_host_pkg::mac_beat_t          o_beat
);

  localparam int NB = `EXT_WORD_W / 8;

  typedef enum logic [2:0] {
    TX_IDLE, TX_FETCH, TX_AWAIT_ACK, TX_SEND, TX_SILENT
  } tx_state_e;

  tx_state_e                     state_q;
  logic [`EXT_BUF_ADDR_W-1:0]    ptr_q;
  logic [`EXT_BUF_ADDR_W-1:0]    last_q;
  logic [NB-1:0]                 mask_q;
  logic [NB-1:0]                 word_dv;
  extractor_host_pkg::mac_beat_t beat_q;

  // Byte count 1..8 to a mask of the low bytes
  function automatic logic [NB-1:0] expand_lwdv(input logic [`EXT_LWDV_W-1:0] lwdv);
    logic [NB-1:0] mask;
    for (int i = 0; i < NB; i++) begin
      mask[i] = (i < int'(lwdv));
    end
    return mask;
  endfunction

  function automatic extractor_host_pkg::mac_word_u tx_word(
    input logic [`EXT_WORD_W-1:0] data,
    input logic [NB-1:0]          dv
  );
    extractor_host_pkg::mac_word_u in_w;
    extractor_host_pkg::mac_word_u out_w;
    in_w.raw = data;
    for (int i = 0; i < NB; i++) begin
      out_w.bytes[i] = dv[i] ? in_w.bytes[NB-1-i] : 8'h00;
    end
    return out_w;
  endfunction

  assign word_dv     = (ptr_q == last_q) ? mask_q : '1;
  assign o_head_done = (state_q == TX_SILENT);
  assign o_beat      = beat_q;

  // Address runs one word ahead of the beat to cover the RAM latency
  always_comb begin
    case (state_q)
      TX_IDLE:      o_rd_addr = '0;
      TX_AWAIT_ACK: o_rd_addr = i_mac_tx_ack ? ptr_q + 1'b1 : ptr_q;
      default:      o_rd_addr = ptr_q + 1'b1;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= TX_IDLE;
      ptr_q   <= '0;
      last_q  <= '0;
      mask_q  <= '0;
      beat_q  <= '0;
    end else begin
      beat_q.start <= 1'b0;
      case (state_q)
        TX_IDLE: begin
          ptr_q <= '0;
          if (i_head.state == extractor_engine_pkg::READING) begin
            last_q  <= i_head.words - 1'b1;
            mask_q  <= expand_lwdv(i_head.last_bytes);
            state_q <= TX_FETCH;
          end
        end
        TX_FETCH: begin
          beat_q.start      <= 1'b1;
          beat_q.data_valid <= '1;
          beat_q.data       <= tx_word(i_rd_data, '1);
          ptr_q             <= ptr_q + 1'b1;
          state_q           <= TX_AWAIT_ACK;
        end
        TX_AWAIT_ACK, TX_SEND: begin
          if (state_q == TX_SEND || i_mac_tx_ack) begin
            beat_q.data_valid <= word_dv;
            beat_q.data       <= tx_word(i_rd_data, word_dv);
            ptr_q             <= ptr_q + 1'b1;
            state_q           <= (ptr_q == last_q) ? TX_SILENT : TX_SEND;
          end
        end
        TX_SILENT: begin
          beat_q  <= '0;
          state_q <= TX_IDLE;
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Valid bytes only go out while the head buffer is being read
  a_dv_in_frame: assert property (@(posedge i_clk) disable iff (i_areset)
    (o_beat.data_valid != '0) |-> i_head.state == extractor_engine_pkg::READING);

endmodule

`default_nettype wire

//--- hw/api_regs.sv
// Wishbone classic register block: identity, scratch and statistics.
// Reading a counter's high word latches its low word for the next read.
// The byte counter adds the valid bytes of every cycle, so a first word
// held for ack is counted once per cycle it is on the port.
`timescale 1ns/10ps
`default_nettype none
`include "extractor_defs.svh"

module api_regs (
  input  wire logic                           i_clk,
  input  wire logic                           i_areset,
  input  wire extractor_host_pkg::wb_req_t    i_wb,
  output logic [31:0]                         o_wb_dat,
  output logic                                o_wb_ack,
  input  wire extractor_host_pkg::mac_beat_t  i_beat
);

  localparam int CNT_W = 64;
  localparam logic [63:0] CORE_NAME = `EXT_CORE_NAME;

  logic [`EXT_API_ADDR_W-1:0] ofs;
  logic                       access;
  logic                       wr_en;
  logic                       rd_en;
  logic [31:0]                rd_word;
  logic [31:0]                scratch_q;
  logic [CNT_W-1:0]           bytes_q;
  logic [CNT_W-1:0]           packets_q;
  logic [31:0]                bytes_lo_q;
  logic [31:0]                packets_lo_q;

  // One access per stb, the master drops stb on ack
  assign access = i_wb.cyc && i_wb.stb && !o_wb_ack;
  assign ofs    = i_wb.adr - `EXT_API_BASE;
  assign wr_en  = access && i_wb.we;
  assign rd_en  = access && !i_wb.we;

  always_comb begin
    rd_word = '0;
    case (ofs)
      `EXT_OFS_NAME0:           rd_word = CORE_NAME[63:32];
      `EXT_OFS_NAME1:           rd_word = CORE_NAME[31:0];
      `EXT_OFS_VERSION:         rd_word = `EXT_CORE_VERSION;
      `EXT_OFS_SCRATCH:         rd_word = scratch_q;
      `EXT_OFS_BYTES:           rd_word = bytes_q[63:32];
      `EXT_OFS_BYTES + 12'd1:   rd_word = bytes_lo_q;
      `EXT_OFS_PACKETS:         rd_word = packets_q[63:32];
      `EXT_OFS_PACKETS + 12'd1: rd_word = packets_lo_q;
      default: ;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      o_wb_ack     <= 1'b0;
      scratch_q    <= '0;
      bytes_q      <= '0;
      packets_q    <= '0;
      bytes_lo_q   <= '0;
      packets_lo_q <= '0;
    end else begin
      o_wb_ack <= access;
      if (wr_en && ofs == `EXT_OFS_SCRATCH) begin
        scratch_q <= i_wb.dat;
      end
      // Snapshot of the low word on a high-word read
      if (rd_en && ofs == `EXT_OFS_BYTES) begin
        bytes_lo_q <= bytes_q[31:0];
      end
      if (rd_en && ofs == `EXT_OFS_PACKETS) begin
        packets_lo_q <= packets_q[31:0];
      end
      if (wr_en && ofs == `EXT_OFS_BYTES) begin
        bytes_q <= '0;
      end else begin
        bytes_q <= bytes_q + CNT_W'($countones(i_beat.data_valid));
      end
      if (wr_en && ofs == `EXT_OFS_PACKETS) begin
        packets_q <= '0;
      end else if (i_beat.start) begin
        packets_q <= packets_q + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (rd_en) begin
      o_wb_dat <= rd_word;
    end
  end

endmodule

`default_nettype wire

//--- hw/nts_extractor.sv
// Packet extractor top level.
// Engines offer packets of 2 to 256 words; they are buffered four deep
// and sent to the MAC in the order they were read.
`timescale 1ns/10ps
`default_nettype none
`include "extractor_defs.svh"

module nts_extractor (
  input  wire logic                                                 i_clk,
  input  wire logic                                                 i_areset,
  input  wire extractor_engine_pkg::engine_req_t [`EXT_ENGINES-1:0] i_engines,
  output extractor_engine_pkg::engine_rsp_t      [`EXT_ENGINES-1:0] o_engines,
  input  wire extractor_host_pkg::wb_req_t                          i_wb,
  output logic [31:0]                                               o_wb_dat,
  output logic                                                      o_wb_ack,
  output logic                                                      o_mac_tx_start,
  input  wire logic                                                 i_mac_tx_ack,
  output logic [`EXT_WORD_W/8-1:0]                                  o_mac_tx_data_valid,
  output logic [`EXT_WORD_W-1:0]                                    o_mac_tx_data
);

  extractor_engine_pkg::engine_req_t sel_req;
  extractor_engine_pkg::engine_rsp_t sel_rsp;
  extractor_engine_pkg::buf_entry_t  head;
  logic                              head_done;
  logic [`EXT_BUF_ADDR_W-1:0]        rd_addr;
  logic [`EXT_WORD_W-1:0]            rd_data;
  extractor_host_pkg::mac_beat_t     beat;

  engine_mux u_mux (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_engines (i_engines),
    .o_engines (o_engines),
    .o_sel_req (sel_req),
    .i_sel_rsp (sel_rsp)
  );

  packet_buffers u_buffers (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_req       (sel_req),
    .o_rsp       (sel_rsp),
    .i_rd_addr   (rd_addr),
    .o_rd_data   (rd_data),
    .o_head      (head),
    .i_head_done (head_done)
  );

  mac_transmitter u_tx (
    .i_clk        (i_clk),
    .i_areset     (i_areset),
    .i_head       (head),
    .o_rd_addr    (rd_addr),
    .i_rd_data    (rd_data),
    .o_head_done  (head_done),
    .i_mac_tx_ack (i_mac_tx_ack),
    .o_beat       (beat)
  );

  api_regs u_api (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_wb     (i_wb),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack),
    .i_beat   (beat)
  );

  assign o_mac_tx_start      = beat.start;
  assign o_mac_tx_data_valid = beat.data_valid;
  assign o_mac_tx_data       = beat.data.raw;

endmodule

`default_nettype wire

//--- dv/tb_nts_extractor.sv
// Testbench for the packet extractor top level.
// Engine, MAC and Wishbone master models run on the falling clock edge.
// Packets are 2 to 24 words with 8-byte words, so buffer counts never wrap.
// The burst phase uses long ack delays to fill all four buffers.
`timescale 1ns/10ps
`default_nettype none
`include "extractor_defs.svh"

module tb_nts_extractor;

  localparam int ENGINES  = `EXT_ENGINES;
  localparam int BUFFERS  = 1 << `EXT_BUF_SEL_W;
  localparam int N_RANDOM = 24;
  localparam int N_BURST  = 16;
  localparam int N_PKT    = N_RANDOM + N_BURST;
  localparam int MAX_LEN  = 24;
  localparam int MARGIN   = 4000;
  localparam logic [63:0] EXP_NAME    = `EXT_CORE_NAME;
  localparam logic [31:0] EXP_VERSION = "0.02";
  localparam logic [11:0] BASE        = `EXT_API_BASE;

  typedef enum int {ENG_IDLE, ENG_OFFER, ENG_SEND, ENG_DONE} eng_state_e;
  typedef enum int {MAC_IDLE, MAC_HOLD, MAC_DATA, MAC_SILENT} mac_state_e;

  logic                                                i_clk;
  logic                                                i_areset;
  extractor_engine_pkg::engine_req_t [ENGINES-1:0]     eng_req;
  extractor_engine_pkg::engine_rsp_t [ENGINES-1:0]     eng_rsp;
  extractor_host_pkg::wb_req_t                         wb_req;
  logic [31:0]                                         wb_dat;
  logic                                                wb_ack;
  logic                                                mac_start;
  logic                                                mac_ack;
  logic [7:0]                                          mac_dv;
  logic [63:0]                                         mac_data;

  // Stimulus store and per-engine packet lists
  logic [63:0] pkt_data [N_PKT][MAX_LEN];
  int          pkt_len  [N_PKT];
  logic [3:0]  pkt_lwdv [N_PKT];
  int          eng_list [ENGINES][N_PKT+1];
  int          eng_cnt [ENGINES];
  int          eng_cnt_random [ENGINES];
  int          eng_rel [ENGINES];
  int          eng_rd [ENGINES];
  int          exp_rd [ENGINES];
  int          eng_ptr [ENGINES];
  eng_state_e  eng_state [ENGINES];

  mac_state_e  mac_state;
  int          cur_eng;
  int          cur_id;
  int          word_idx;
  int          hold_cnt;
  int          hold_len;
  logic        long_ack;

  int          errors;
  int          checks;
  int          frames_done;
  int          occupancy;
  int          max_occ;
  int          total_words;
  int          watchdog_cycles;
  logic [63:0] exp_bytes;
  logic [31:0] lcg_state;
  logic [31:0] scratch_val;

  nts_extractor u_dut (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_engines           (eng_req),
    .o_engines           (eng_rsp),
    .i_wb                (wb_req),
    .o_wb_dat            (wb_dat),
    .o_wb_ack            (wb_ack),
    .o_mac_tx_start      (mac_start),
    .i_mac_tx_ack        (mac_ack),
    .o_mac_tx_data_valid (mac_dv),
    .o_mac_tx_data       (mac_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // --------------------------------------------------------------------------
  // Random numbers and expected data
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(lcg_next() >> 8) % n;
  endfunction

  // Byte count 1..8 to a mask of the low bytes
  function automatic logic [7:0] last_mask(input logic [3:0] lwdv);
    logic [8:0] ones;
    ones = (9'd1 << lwdv) - 9'd1;
    return ones[7:0];
  endfunction

  // Output byte i is input byte 7-i, zero where not valid
  function automatic logic [63:0] reverse_masked(input logic [63:0] w, input logic [7:0] dv);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < 8; i++) begin
      if (dv[i]) begin
        r[8*i +: 8] = w[56-8*i +: 8];
      end
    end
    return r;
  endfunction

  task automatic compare_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic make_packets();
    int e;
    for (int id = 0; id < N_PKT; id++) begin
      e = rand_below(ENGINES);
      pkt_len[id]  = 2 + rand_below(MAX_LEN - 1);
      pkt_lwdv[id] = 4'(1 + rand_below(8));
      // First word carries engine and sequence number
      pkt_data[id][0] = {8'ha5, 8'(e), 16'(id), lcg_next()};
      for (int w = 1; w < pkt_len[id]; w++) begin
        pkt_data[id][w] = {lcg_next(), lcg_next()};
      end
      eng_list[e][eng_cnt[e]] = id;
      eng_cnt[e]++;
      total_words += pkt_len[id];
      if (id == N_RANDOM - 1) begin
        for (int k = 0; k < ENGINES; k++) begin
          eng_cnt_random[k] = eng_cnt[k];
        end
      end
    end
  endtask

  task automatic release_packets(input logic burst);
    for (int e = 0; e < ENGINES; e++) begin
      eng_rel[e] = burst ? eng_cnt[e] : eng_cnt_random[e];
    end
  endtask

  // --------------------------------------------------------------------------
  // Engine and MAC models
  // --------------------------------------------------------------------------
  task automatic drive_engines();
    int id;
    for (int e = 0; e < ENGINES; e++) begin
      id = eng_list[e][eng_rd[e]];
      if (eng_rsp[e].fifo_rd_start) begin
        checks++;
        if (eng_state[e] != ENG_OFFER) begin
          errors++;
          $display("fifo_rd_start to engine %0d with no packet offered", e);
        end
        if (occupancy >= BUFFERS) begin
          errors++;
          $display("fifo_rd_start to engine %0d while all buffers are full", e);
        end
        occupancy++;
        if (occupancy > max_occ) begin
          max_occ = occupancy;
        end
        eng_state[e] = ENG_SEND;
        eng_ptr[e]   = 0;
      end else if (eng_rsp[e].packet_read) begin
        checks++;
        if (eng_state[e] != ENG_DONE) begin
          errors++;
          $display("packet_read to engine %0d before its FIFO was empty", e);
        end
        eng_rd[e]++;
        eng_state[e]          = ENG_IDLE;
        eng_req[e]            = '0;
        eng_req[e].fifo_empty = 1'b1;
      end else begin
        case (eng_state[e])
          ENG_IDLE: begin
            if (eng_rd[e] < eng_rel[e]) begin
              eng_req[e].packet_available = 1'b1;
              eng_req[e].fifo_empty       = 1'b0;
              eng_req[e].bytes_last_word  = pkt_lwdv[id];
              eng_state[e]                = ENG_OFFER;
            end
          end
          ENG_SEND: begin
            if (eng_ptr[e] == pkt_len[id]) begin
              eng_req[e].fifo_rd_valid = 1'b0;
              eng_req[e].fifo_empty    = 1'b1;
              eng_state[e]             = ENG_DONE;
            end else if (rand_below(4) == 0) begin
              eng_req[e].fifo_rd_valid = 1'b0;
            end else begin
              eng_req[e].fifo_rd_valid = 1'b1;
              eng_req[e].fifo_rd_data  = pkt_data[id][eng_ptr[e]];
              eng_ptr[e]++;
            end
          end
          default: ;
        endcase
      end
    end
  endtask

  task automatic check_beat(input int id, input int w, input logic exp_start);
    logic [7:0] dv;
    dv = (w == pkt_len[id] - 1) ? last_mask(pkt_lwdv[id]) : 8'hff;
    compare_hex($sformatf("o_mac_tx_start pkt %0d word %0d", id, w),
                64'(mac_start), 64'(exp_start));
    compare_hex($sformatf("o_mac_tx_data_valid pkt %0d word %0d", id, w),
                64'(mac_dv), 64'(dv));
    compare_hex($sformatf("o_mac_tx_data pkt %0d word %0d", id, w),
                mac_data, reverse_masked(pkt_data[id][w], dv));
  endtask

  // Ack once the hold count runs out
  task automatic step_ack_hold();
    if (hold_cnt == 0) begin
      mac_ack   = 1'b1;
      mac_state = MAC_DATA;
      word_idx  = 1;
    end else begin
      mac_ack   = 1'b0;
      hold_cnt--;
      mac_state = MAC_HOLD;
    end
  endtask

  task automatic watch_mac();
    case (mac_state)
      MAC_IDLE: begin
        mac_ack = 1'b0;
        if (mac_start) begin
          cur_eng = int'(mac_data[15:8]);
          if (cur_eng >= ENGINES || exp_rd[cur_eng] >= eng_rel[cur_eng]) begin
            errors++;
            $display("Frame starting with %h matches no pending packet", mac_data);
            mac_ack = 1'b1;
          end else begin
            cur_id   = eng_list[cur_eng][exp_rd[cur_eng]];
            check_beat(cur_id, 0, 1'b1);
            hold_len = long_ack ? 100 + rand_below(8) : rand_below(6);
            hold_cnt = hold_len;
            step_ack_hold();
          end
        end else if (mac_dv != 8'h00) begin
          errors++;
          $display("Data valid %h on the MAC port outside a frame", mac_dv);
        end
      end
      MAC_HOLD: begin
        check_beat(cur_id, 0, 1'b0);
        step_ack_hold();
      end
      MAC_DATA: begin
        mac_ack = 1'b0;
        check_beat(cur_id, word_idx, 1'b0);
        word_idx++;
        if (word_idx == pkt_len[cur_id]) begin
          occupancy--;
          mac_state = MAC_SILENT;
        end
      end
      default: begin
        compare_hex("o_mac_tx_start silent", 64'(mac_start), 64'h0);
        compare_hex("o_mac_tx_data_valid silent", 64'(mac_dv), 64'h0);
        compare_hex("o_mac_tx_data silent", mac_data, 64'h0);
        // First word counts once per cycle it is held on the port
        exp_bytes += 64'(8 * (hold_len + 1) + 8 * (pkt_len[cur_id] - 2) +
                         int'(pkt_lwdv[cur_id]));
        exp_rd[cur_eng]++;
        frames_done++;
        mac_state = MAC_IDLE;
      end
    endcase
  endtask

  always @(negedge i_clk) begin
    if (!i_areset) begin
      drive_engines();
      watch_mac();
    end
  end

  // --------------------------------------------------------------------------
  // Wishbone master
  // --------------------------------------------------------------------------
  task automatic wb_access(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    @(negedge i_clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    @(negedge i_clk);
    checks++;
    if (!wb_ack) begin
      errors++;
      $display("No Wishbone ack one cycle after stb, address %h", adr);
    end
    rdat   = wb_dat;
    wb_req = '0;
    @(negedge i_clk);
    checks++;
    if (wb_ack) begin
      errors++;
      $display("Wishbone ack held longer than one cycle, address %h", adr);
    end
  endtask

  task automatic check_reg(input logic [11:0] adr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    wb_access(1'b0, adr, 32'h0, rd);
    compare_hex(name, 64'(rd), 64'(exp));
  endtask

  task automatic write_reg(input logic [11:0] adr, input logic [31:0] dat);
    logic [31:0] unused_rd;
    wb_access(1'b1, adr, dat, unused_rd);
  endtask

  // High word first so the low word is a snapshot
  task automatic check_counter(input logic [11:0] ofs, input logic [63:0] exp, input string name);
    check_reg(BASE + ofs, exp[63:32], {name, " high"});
    check_reg(BASE + ofs + 12'd1, exp[31:0], {name, " low"});
  endtask

  task automatic wait_frames(input int n);
    while (frames_done < n) begin
      @(posedge i_clk);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    i_areset  = 1'b1;
    wb_req    = '0;
    mac_ack   = 1'b0;
    mac_state = MAC_IDLE;
    long_ack  = 1'b0;
    exp_bytes = '0;
    lcg_state = 32'd65146;
    for (int e = 0; e < ENGINES; e++) begin
      eng_req[e]            = '0;
      eng_req[e].fifo_empty = 1'b1;
      eng_state[e]          = ENG_IDLE;
      eng_cnt[e]            = 0;
      eng_rel[e]            = 0;
      eng_rd[e]             = 0;
      exp_rd[e]             = 0;
    end
    make_packets();
    scratch_val     = lcg_next();
    watchdog_cycles = total_words * 20 + MARGIN;

    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_areset = 1'b0;
    @(negedge i_clk);
    compare_hex("o_mac_tx_start", 64'(mac_start), 64'h0);
    compare_hex("o_mac_tx_data_valid", 64'(mac_dv), 64'h0);
    compare_hex("o_wb_ack", 64'(wb_ack), 64'h0);
    compare_hex("o_engines", 64'(eng_rsp), 64'h0);

    check_reg(BASE + `EXT_OFS_NAME0, EXP_NAME[63:32], "name word 0");
    check_reg(BASE + `EXT_OFS_NAME1, EXP_NAME[31:0], "name word 1");
    check_reg(BASE + `EXT_OFS_VERSION, EXP_VERSION, "version");
    write_reg(BASE + `EXT_OFS_SCRATCH, scratch_val);
    check_reg(BASE + `EXT_OFS_SCRATCH, scratch_val, "scratch");

    // Random traffic with short ack delays
    @(posedge i_clk);
    release_packets(1'b0);
    wait_frames(N_RANDOM);

    // Burst that overruns the four buffers
    @(posedge i_clk);
    max_occ  = 0;
    long_ack = 1'b1;
    release_packets(1'b1);
    wait_frames(N_PKT);
    checks++;
    if (max_occ != BUFFERS) begin
      errors++;
      $display("Buffers were never all full during the burst, peak %0d", max_occ);
    end

    check_counter(`EXT_OFS_BYTES, exp_bytes, "byte counter");
    check_counter(`EXT_OFS_PACKETS, 64'(frames_done), "packet counter");
    write_reg(BASE + `EXT_OFS_BYTES, 32'h0);
    write_reg(BASE + `EXT_OFS_PACKETS, 32'h0);
    check_counter(`EXT_OFS_BYTES, 64'h0, "cleared byte counter");
    check_counter(`EXT_OFS_PACKETS, 64'h0, "cleared packet counter");

    $display("Summary: %0d checks, %0d errors, %0d of %0d frames",
             checks, errors, frames_done, N_PKT);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge i_clk);
    $display("Timeout after %0d cycles, %0d of %0d frames seen, %0d errors",
             watchdog_cycles, frames_done, N_PKT, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/extractor_engine_pkg.sv
hw/extractor_host_pkg.sv
hw/engine_mux.sv
hw/packet_buffers.sv
hw/mac_transmitter.sv
hw/api_regs.sv
hw/nts_extractor.sv
dv/tb_nts_extractor.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_nts_extractor -f files.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
